/* Bender.yml */
package:
  name: lsq

sources:
  - lsq_pkg.sv
  - lsq_addr_queue.sv
  - lsq_entry_table.sv
  - lsq_issue_select.sv
  - lsq_top.sv
  - target: test
    files:
      - tb_lsq_top.sv

/* lsq_addr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_addr_queue #(
	parameter int AQ_DEPTH = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_push,
	input  lsq_pkg::aq_entry_t i_push_entry,
	output logic o_aq_ready,
	input  lsq_pkg::cdb_t i_cdb,
	output lsq_pkg::addr_wb_t o_addr_wb
);
	import lsq_pkg::*;

	localparam int PTR_W = $clog2(AQ_DEPTH);
	localparam int CNT_W = $clog2(AQ_DEPTH + 1);

	aq_entry_t aq_mem [AQ_DEPTH];
	aq_entry_t push_w;
	aq_entry_t head_e;
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic [ADDR_W-1:0] imm_ext;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(AQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_comb begin
		push_w = i_push_entry;
		push_w.base = wake(i_push_entry.base, i_cdb); // producer may finish in the push cycle
		head_e = aq_mem[head];
		imm_ext = {{(ADDR_W - IMM_W){head_e.imm[IMM_W-1]}}, head_e.imm};
		pop = (count != '0) && (head_e.base.tag == '0); // oldest base ready
		o_aq_ready = (count != CNT_W'(AQ_DEPTH));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (i_push)
				tail <= ptr_inc(tail);
			if (pop)
				head <= ptr_inc(head);
			count <= count + CNT_W'(i_push) - CNT_W'(pop);
		end
	end

	// stale entries also watch the bus, they get overwritten on push anyway
	always_ff @(posedge clk) begin
		for (int i = 0; i < AQ_DEPTH; i++) begin
			if (i_push && tail == PTR_W'(i))
				aq_mem[i] <= push_w;
			else
				aq_mem[i].base <= wake(aq_mem[i].base, i_cdb);
		end
	end

	// address goes out registered, one pulse per popped entry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_addr_wb <= '0;
		end else begin
			o_addr_wb.valid <= pop;
			if (pop) begin
				o_addr_wb.is_store <= head_e.is_store;
				o_addr_wb.slot <= head_e.slot;
				o_addr_wb.addr <= ADDR_W'(head_e.base.value) + imm_ext;
			end
		end
	end

	no_push_when_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_push |-> (count != CNT_W'(AQ_DEPTH))
	) else $error("address queue pushed while full");

endmodule

`default_nettype wire

/* lsq_entry_table.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_entry_table #(
	parameter int NUM_LOAD = 4,
	parameter int NUM_STORE = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_iq_valid,
	output logic o_iq_ready,
	input  lsq_pkg::iq_req_t i_iq_req,
	output logic o_push,
	output lsq_pkg::aq_entry_t o_push_entry,
	input  logic i_aq_ready,
	input  lsq_pkg::cdb_t i_cdb,
	input  lsq_pkg::addr_wb_t i_addr_wb,
	output logic [NUM_LOAD-1:0] o_load_ready,
	output logic [NUM_STORE-1:0] o_store_ready,
	output lsq_pkg::mem_req_t [NUM_LOAD-1:0] o_load_req,
	output lsq_pkg::mem_req_t [NUM_STORE-1:0] o_store_req,
	input  logic [NUM_LOAD-1:0] i_load_issue,
	input  logic [NUM_STORE-1:0] i_store_issue
);
	import lsq_pkg::*;

	logic [NUM_LOAD-1:0] ld_valid;
	logic [NUM_LOAD-1:0] ld_addr_valid;
	logic [TAG_W-1:0] ld_tag [NUM_LOAD];
	logic [ADDR_W-1:0] ld_addr [NUM_LOAD];
	logic [NUM_STORE-1:0] ld_st_dep [NUM_LOAD]; // older stores, same address

	logic [NUM_STORE-1:0] st_valid;
	logic [NUM_STORE-1:0] st_addr_valid;
	logic [TAG_W-1:0] st_tag [NUM_STORE];
	logic [ADDR_W-1:0] st_addr [NUM_STORE];
	operand_t st_data [NUM_STORE];
	logic [NUM_LOAD-1:0] st_ld_dep [NUM_STORE];
	logic [NUM_STORE-1:0] st_st_dep [NUM_STORE];

	logic [NUM_LOAD-1:0] ld_free, ld_alloc, ld_wb, ld_match;
	logic [NUM_STORE-1:0] st_free, st_alloc, st_wb, st_match;
	logic [SLOT_W:0] ld_pick; // {found, index}
	logic [SLOT_W:0] st_pick;
	logic accept;

	function automatic logic [SLOT_W:0] first_set(input logic [MAX_SLOTS-1:0] vec);
		logic [SLOT_W:0] res;
		res = '0;
		for (int k = MAX_SLOTS - 1; k >= 0; k--) begin
			if (vec[k])
				res = {1'b1, SLOT_W'(k)};
		end
		return res;
	endfunction

	// allocation of the lowest free slot of the requested kind
	always_comb begin
		ld_free = ~ld_valid;
		st_free = ~st_valid;
		ld_pick = first_set(MAX_SLOTS'(ld_free));
		st_pick = first_set(MAX_SLOTS'(st_free));
		o_iq_ready = i_aq_ready & (i_iq_req.is_store ? st_pick[SLOT_W] : ld_pick[SLOT_W]);
		accept = i_iq_valid & o_iq_ready;
		o_push = accept;
		o_push_entry.slot = i_iq_req.is_store ? st_pick[SLOT_W-1:0] : ld_pick[SLOT_W-1:0];
		o_push_entry.is_store = i_iq_req.is_store;
		o_push_entry.imm = i_iq_req.imm;
		o_push_entry.base = i_iq_req.base;
		for (int i = 0; i < NUM_LOAD; i++)
			ld_alloc[i] = accept & !i_iq_req.is_store & (ld_pick[SLOT_W-1:0] == SLOT_W'(i));
		for (int i = 0; i < NUM_STORE; i++)
			st_alloc[i] = accept & i_iq_req.is_store & (st_pick[SLOT_W-1:0] == SLOT_W'(i));
	end

	// entries with a valid address are all older, the queue is in order
	always_comb begin
		for (int i = 0; i < NUM_LOAD; i++) begin
			ld_wb[i] = i_addr_wb.valid & !i_addr_wb.is_store & (i_addr_wb.slot == SLOT_W'(i));
			ld_match[i] = ld_addr_valid[i] & !i_load_issue[i] & (ld_addr[i] == i_addr_wb.addr);
		end
		for (int i = 0; i < NUM_STORE; i++) begin
			st_wb[i] = i_addr_wb.valid & i_addr_wb.is_store & (i_addr_wb.slot == SLOT_W'(i));
			st_match[i] = st_addr_valid[i] & !i_store_issue[i] & (st_addr[i] == i_addr_wb.addr);
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LOAD; i++) begin
			o_load_ready[i] = ld_valid[i] & ld_addr_valid[i] & (ld_st_dep[i] == '0);
			o_load_req[i].tag = ld_tag[i];
			o_load_req[i].is_store = 1'b0;
			o_load_req[i].addr = ld_addr[i];
			o_load_req[i].wdata = '0;
		end
		for (int i = 0; i < NUM_STORE; i++) begin
			o_store_ready[i] = st_valid[i] & st_addr_valid[i] & (st_ld_dep[i] == '0)
				& (st_st_dep[i] == '0) & (st_data[i].tag == '0);
			o_store_req[i].tag = st_tag[i];
			o_store_req[i].is_store = 1'b1;
			o_store_req[i].addr = st_addr[i];
			o_store_req[i].wdata = st_data[i].value;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_valid <= '0;
			ld_addr_valid <= '0;
			st_valid <= '0;
			st_addr_valid <= '0;
			for (int i = 0; i < NUM_LOAD; i++)
				ld_st_dep[i] <= '0;
			for (int i = 0; i < NUM_STORE; i++) begin
				st_ld_dep[i] <= '0;
				st_st_dep[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_LOAD; i++) begin
				if (ld_alloc[i])
					ld_valid[i] <= 1'b1;
				else if (i_load_issue[i])
					ld_valid[i] <= 1'b0;
				if (ld_wb[i])
					ld_addr_valid[i] <= 1'b1;
				else if (i_load_issue[i])
					ld_addr_valid[i] <= 1'b0;
				ld_st_dep[i] <= ld_wb[i] ? st_match : (ld_st_dep[i] & ~i_store_issue);
			end
			for (int i = 0; i < NUM_STORE; i++) begin
				if (st_alloc[i])
					st_valid[i] <= 1'b1;
				else if (i_store_issue[i])
					st_valid[i] <= 1'b0;
				if (st_wb[i])
					st_addr_valid[i] <= 1'b1;
				else if (i_store_issue[i])
					st_addr_valid[i] <= 1'b0;
				st_ld_dep[i] <= st_wb[i] ? ld_match : (st_ld_dep[i] & ~i_load_issue);
				st_st_dep[i] <= st_wb[i] ? st_match : (st_st_dep[i] & ~i_store_issue);
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_LOAD; i++) begin
			if (ld_alloc[i])
				ld_tag[i] <= i_iq_req.tag;
			if (ld_wb[i])
				ld_addr[i] <= i_addr_wb.addr;
		end
		for (int i = 0; i < NUM_STORE; i++) begin
			if (st_alloc[i]) begin
				st_tag[i] <= i_iq_req.tag;
				st_data[i] <= wake(i_iq_req.data, i_cdb);
			end else begin
				st_data[i] <= wake(st_data[i], i_cdb); // store data wakeup
			end
			if (st_wb[i])
				st_addr[i] <= i_addr_wb.addr;
		end
	end

	wb_targets_live_slot: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_addr_wb.valid |-> ((|(ld_wb & ld_valid & ~ld_addr_valid))
			|| (|(st_wb & st_valid & ~st_addr_valid)))
	) else $error("address write-back to a slot that is not waiting for one");

endmodule

`default_nettype wire

/* lsq_issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_issue_select #(
	parameter int NUM_LOAD = 4,
	parameter int NUM_STORE = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [NUM_LOAD-1:0] i_load_ready,
	input  logic [NUM_STORE-1:0] i_store_ready,
	input  lsq_pkg::mem_req_t [NUM_LOAD-1:0] i_load_req,
	input  lsq_pkg::mem_req_t [NUM_STORE-1:0] i_store_req,
	output logic o_mu_valid,
	input  logic i_mu_ready,
	output lsq_pkg::mem_req_t o_mu_req,
	output logic [NUM_LOAD-1:0] o_load_issue,
	output logic [NUM_STORE-1:0] o_store_issue
);
	import lsq_pkg::*;

	logic [SLOT_W-1:0] ld_ptr;
	logic [SLOT_W-1:0] st_ptr;
	logic [MAX_SLOTS-1:0] ld_rdy_w;
	logic [MAX_SLOTS-1:0] st_rdy_w;
	logic [SLOT_W:0] ld_pick; // {found, index}
	logic [SLOT_W:0] st_pick;
	logic ld_go;
	logic st_go;

	// first ready candidate at or after the pointer, wrapping at n
	function automatic logic [SLOT_W:0] rr_pick(input logic [MAX_SLOTS-1:0] rdy,
			input logic [SLOT_W-1:0] ptr, input int n);
		logic found;
		logic [SLOT_W-1:0] idx;
		int j;
		found = 1'b0;
		idx = '0;
		for (int k = 0; k < MAX_SLOTS; k++) begin
			if (k < n) begin
				j = int'(ptr) + k;
				if (j >= n)
					j = j - n;
				if (!found && rdy[j]) begin
					found = 1'b1;
					idx = SLOT_W'(j);
				end
			end
		end
		return {found, idx};
	endfunction

	function automatic logic [SLOT_W-1:0] ptr_next(input logic [SLOT_W-1:0] p, input int n);
		return (p == SLOT_W'(n - 1)) ? '0 : p + 1'b1;
	endfunction

	always_comb begin
		ld_rdy_w = MAX_SLOTS'(i_load_ready);
		st_rdy_w = MAX_SLOTS'(i_store_ready);
		ld_pick = rr_pick(ld_rdy_w, ld_ptr, NUM_LOAD);
		st_pick = rr_pick(st_rdy_w, st_ptr, NUM_STORE);
		o_mu_valid = ld_pick[SLOT_W] | st_pick[SLOT_W];
		ld_go = ld_pick[SLOT_W] & i_mu_ready; // loads win over stores
		st_go = !ld_pick[SLOT_W] & st_pick[SLOT_W] & i_mu_ready;
		if (ld_pick[SLOT_W])
			o_mu_req = i_load_req[ld_pick[SLOT_W-1:0]];
		else
			o_mu_req = i_store_req[st_pick[SLOT_W-1:0]];
		o_load_issue = ld_go ? (NUM_LOAD'(1) << ld_pick[SLOT_W-1:0]) : '0;
		o_store_issue = st_go ? (NUM_STORE'(1) << st_pick[SLOT_W-1:0]) : '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_ptr <= '0;
			st_ptr <= '0;
		end else begin
			if (ld_go)
				ld_ptr <= ptr_next(ld_pick[SLOT_W-1:0], NUM_LOAD);
			if (st_go)
				st_ptr <= ptr_next(st_pick[SLOT_W-1:0], NUM_STORE);
		end
	end

	issue_matches_kind: assert property (
		@(posedge clk) disable iff (!rst_n)
		((|o_load_issue) || (|o_store_issue))
			|-> (o_mu_req.is_store == (|o_store_issue))
	) else $error("issued request kind differs from the issued slot kind");

endmodule

`default_nettype wire

/* lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int TAG_W = 4; // tag zero means the value is present
	localparam int IMM_W = 12;
	localparam int SLOT_W = 3;
	localparam int MAX_SLOTS = 1 << SLOT_W;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [DATA_W-1:0] value;
	} operand_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag; // tag of the memory operation itself
		logic is_store;
		operand_t base;
		operand_t data; // only meaningful for stores
		logic [IMM_W-1:0] imm;
	} iq_req_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [DATA_W-1:0] data;
	} cdb_t;

	typedef struct packed {
		logic [SLOT_W-1:0] slot;
		logic is_store;
		logic [IMM_W-1:0] imm;
		operand_t base;
	} aq_entry_t;

	typedef struct packed {
		logic valid;
		logic is_store;
		logic [SLOT_W-1:0] slot;
		logic [ADDR_W-1:0] addr;
	} addr_wb_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic is_store;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	// operand picks up the broadcast value when its producer tag is on the bus
	function automatic operand_t wake(input operand_t op, input cdb_t cdb);
		operand_t res;
		res = op;
		if (cdb.valid && cdb.tag == op.tag) begin
			res.tag = '0;
			res.value = cdb.data;
		end
		return res;
	endfunction

endpackage

`default_nettype wire

/* lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_top #(
	parameter int NUM_LOAD = 4,
	parameter int NUM_STORE = 4,
	parameter int AQ_DEPTH = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_iq_valid,
	output logic o_iq_ready,
	input  lsq_pkg::iq_req_t i_iq_req,
	input  lsq_pkg::cdb_t i_cdb,
	output logic o_mu_valid,
	input  logic i_mu_ready,
	output lsq_pkg::mem_req_t o_mu_req
);
	import lsq_pkg::*;

	logic push;
	aq_entry_t push_entry;
	logic aq_ready;
	addr_wb_t addr_wb; // queue to table, one clock after pop decision
	logic [NUM_LOAD-1:0] load_ready;
	logic [NUM_LOAD-1:0] load_issue;
	logic [NUM_STORE-1:0] store_ready;
	logic [NUM_STORE-1:0] store_issue;
	mem_req_t [NUM_LOAD-1:0] load_req;
	mem_req_t [NUM_STORE-1:0] store_req;

	lsq_entry_table #(
		.NUM_LOAD(NUM_LOAD),
		.NUM_STORE(NUM_STORE)
	) u_table (
		.clk(clk),
		.rst_n(rst_n),
		.i_iq_valid(i_iq_valid),
		.o_iq_ready(o_iq_ready),
		.i_iq_req(i_iq_req),
		.o_push(push),
		.o_push_entry(push_entry),
		.i_aq_ready(aq_ready),
		.i_cdb(i_cdb),
		.i_addr_wb(addr_wb),
		.o_load_ready(load_ready),
		.o_store_ready(store_ready),
		.o_load_req(load_req),
		.o_store_req(store_req),
		.i_load_issue(load_issue),
		.i_store_issue(store_issue)
	);

	lsq_addr_queue #(
		.AQ_DEPTH(AQ_DEPTH)
	) u_addr_queue (
		.clk(clk),
		.rst_n(rst_n),
		.i_push(push),
		.i_push_entry(push_entry),
		.o_aq_ready(aq_ready),
		.i_cdb(i_cdb),
		.o_addr_wb(addr_wb)
	);

	lsq_issue_select #(
		.NUM_LOAD(NUM_LOAD),
		.NUM_STORE(NUM_STORE)
	) u_select (
		.clk(clk),
		.rst_n(rst_n),
		.i_load_ready(load_ready),
		.i_store_ready(store_ready),
		.i_load_req(load_req),
		.i_store_req(store_req),
		.o_mu_valid(o_mu_valid),
		.i_mu_ready(i_mu_ready),
		.o_mu_req(o_mu_req),
		.o_load_issue(load_issue),
		.o_store_issue(store_issue)
	);

endmodule

`default_nettype wire

/* tb_lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsq_top;
	import lsq_pkg::*;

	localparam int DRIVE = 2;
	localparam int TIMEOUT = 100;
	localparam int NT = 1 << TAG_W;
	localparam logic [31:0] SEED = 32'hd7a1_1af0;

	logic clk;
	logic rst_n;
	logic i_iq_valid;
	logic o_iq_ready;
	iq_req_t i_iq_req;
	cdb_t i_cdb;
	logic o_mu_valid;
	logic i_mu_ready;
	mem_req_t o_mu_req;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int mu_mode; // 0 ready, 1 stalled, 2 random stalls
	logic [TAG_W-1:0] tag_ctr;

	// reference model, indexed by the operation's own tag
	logic pend [NT];
	logic is_st [NT];
	logic [TAG_W-1:0] b_tag [NT];
	logic [DATA_W-1:0] b_val [NT];
	logic [TAG_W-1:0] d_tag [NT];
	logic [DATA_W-1:0] d_val [NT];
	logic [IMM_W-1:0] imm_r [NT];
	int seq [NT];
	logic [ADDR_W-1:0] exp_addr [NT];
	int seq_cnt, accept_cnt, issue_cnt;

	logic hs, tag_pending, fields_ok, unblocked, order_ok;
	logic [TAG_W-1:0] ht;

	lsq_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.i_iq_valid(i_iq_valid),
		.o_iq_ready(o_iq_ready),
		.i_iq_req(i_iq_req),
		.i_cdb(i_cdb),
		.o_mu_valid(o_mu_valid),
		.i_mu_ready(i_mu_ready),
		.o_mu_req(o_mu_req)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		#DRIVE;
		case (mu_mode)
			0: i_mu_ready = 1'b1;
			1: i_mu_ready = 1'b0;
			default: i_mu_ready = ($urandom % 3) != 0;
		endcase
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < NT; k++)
				pend[k] <= 1'b0;
			seq_cnt <= 0;
			accept_cnt <= 0;
			issue_cnt <= 0;
		end else begin
			for (int k = 0; k < NT; k++) begin
				if (i_cdb.valid && pend[k] && b_tag[k] == i_cdb.tag) begin
					b_tag[k] <= '0;
					b_val[k] <= i_cdb.data;
				end
				if (i_cdb.valid && pend[k] && is_st[k] && d_tag[k] == i_cdb.tag) begin
					d_tag[k] <= '0;
					d_val[k] <= i_cdb.data;
				end
			end
			if (o_mu_valid && i_mu_ready) begin
				pend[o_mu_req.tag] <= 1'b0;
				issue_cnt <= issue_cnt + 1;
			end
			if (i_iq_valid && o_iq_ready) begin
				pend[i_iq_req.tag] <= 1'b1;
				is_st[i_iq_req.tag] <= i_iq_req.is_store;
				imm_r[i_iq_req.tag] <= i_iq_req.imm;
				seq[i_iq_req.tag] <= seq_cnt;
				seq_cnt <= seq_cnt + 1;
				accept_cnt <= accept_cnt + 1;
				// a broadcast in the accept cycle already counts
				if (i_cdb.valid && i_cdb.tag == i_iq_req.base.tag) begin
					b_tag[i_iq_req.tag] <= '0;
					b_val[i_iq_req.tag] <= i_cdb.data;
				end else begin
					b_tag[i_iq_req.tag] <= i_iq_req.base.tag;
					b_val[i_iq_req.tag] <= i_iq_req.base.value;
				end
				if (i_cdb.valid && i_cdb.tag == i_iq_req.data.tag) begin
					d_tag[i_iq_req.tag] <= '0;
					d_val[i_iq_req.tag] <= i_cdb.data;
				end else begin
					d_tag[i_iq_req.tag] <= i_iq_req.data.tag;
					d_val[i_iq_req.tag] <= i_iq_req.data.value;
				end
			end
		end
	end

	always_comb begin
		for (int k = 0; k < NT; k++)
			exp_addr[k] = b_val[k] + {{(ADDR_W - IMM_W){imm_r[k][IMM_W-1]}}, imm_r[k]};
		ht = o_mu_req.tag;
		hs = o_mu_valid & i_mu_ready;
		tag_pending = pend[ht];
		fields_ok = (is_st[ht] == o_mu_req.is_store) && (exp_addr[ht] == o_mu_req.addr)
			&& (!is_st[ht] || d_val[ht] == o_mu_req.wdata);
		unblocked = (b_tag[ht] == '0) && (!is_st[ht] || d_tag[ht] == '0);
		order_ok = 1'b1;
		// older same-address entry of a conflicting kind still waiting
		for (int k = 0; k < NT; k++) begin
			if (pend[k] && TAG_W'(k) != ht && seq[k] < seq[ht] && b_tag[k] == '0
					&& exp_addr[k] == exp_addr[ht] && (is_st[k] || is_st[ht]))
				order_ok = 1'b0;
		end
	end

	issue_is_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		hs |-> tag_pending)
	else begin
		errors++;
		$display("MISMATCH at %0t: tag %0d issued but not outstanding", $time, ht);
	end

	issue_fields: assert property (@(posedge clk) disable iff (!rst_n)
		hs && tag_pending |-> fields_ok)
	else begin
		errors++;
		$display("MISMATCH at %0t: wrong request for tag %0d", $time, ht);
	end

	issue_after_wakeup: assert property (@(posedge clk) disable iff (!rst_n)
		hs && tag_pending |-> unblocked)
	else begin
		errors++;
		$display("MISMATCH at %0t: tag %0d issued before its operand arrived", $time, ht);
	end

	issue_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		hs && tag_pending |-> order_ok)
	else begin
		errors++;
		$display("MISMATCH at %0t: tag %0d passed an older same-address entry", $time, ht);
	end

	valid_held: assert property (@(posedge clk) disable iff (!rst_n)
		o_mu_valid && !i_mu_ready |=> o_mu_valid)
	else begin
		errors++;
		$display("MISMATCH at %0t: o_mu_valid dropped without a handshake", $time);
	end

	function automatic logic [TAG_W-1:0] new_tag();
		tag_ctr = (tag_ctr == TAG_W'(NT - 1)) ? TAG_W'(1) : tag_ctr + 1'b1;
		return tag_ctr;
	endfunction

	function automatic operand_t make_operand(input logic [TAG_W-1:0] t,
			input logic [DATA_W-1:0] v);
		operand_t op;
		op.tag = t;
		op.value = v;
		return op;
	endfunction

	function automatic logic any_pending();
		logic res;
		res = 1'b0;
		for (int k = 0; k < NT; k++)
			res = res | pend[k];
		return res;
	endfunction

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			errors++;
			$display("MISMATCH at %0t: %s", $time, msg);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#DRIVE;
	endtask

	task automatic send_op(input logic [TAG_W-1:0] tag, input logic st, input operand_t base,
			input operand_t data, input logic [IMM_W-1:0] imm);
		logic accepted;
		int n;
		accepted = 1'b0;
		i_iq_valid = 1'b1;
		i_iq_req.tag = tag;
		i_iq_req.is_store = st;
		i_iq_req.base = base;
		i_iq_req.data = data;
		i_iq_req.imm = imm;
		for (n = 0; n < TIMEOUT && !accepted; n++) begin
			#1;
			accepted = o_iq_ready; // stable until the next edge
			@(posedge clk);
			#DRIVE;
		end
		i_iq_valid = 1'b0;
		if (!accepted) begin
			errors++;
			$display("timed out waiting for the station to accept tag %0d", tag);
		end
	endtask

	task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
		i_cdb.valid = 1'b1;
		i_cdb.tag = tag;
		i_cdb.data = data;
		@(posedge clk);
		#DRIVE;
		i_cdb = '0;
	endtask

	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while (any_pending() && n < TIMEOUT) begin
			@(posedge clk);
			#DRIVE;
			n++;
		end
		if (any_pending()) begin
			errors++;
			$display("timed out waiting for the %s to reach the memory unit", what);
		end
	endtask

	task automatic wait_issue(input logic [TAG_W-1:0] tag);
		int n;
		n = 0;
		while (pend[tag] && n < TIMEOUT) begin
			@(posedge clk);
			#DRIVE;
			n++;
		end
		if (pend[tag]) begin
			errors++;
			$display("timed out waiting for tag %0d to issue", tag);
		end
	endtask

	task automatic end_test(input string name, input int e0);
		tests_run++;
		if (errors == e0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d error(s)", name, errors - e0);
		end
	endtask

	task automatic test_reset();
		int e0;
		logic rdy;
		e0 = errors;
		check_true(!o_mu_valid, "o_mu_valid high after reset");
		i_iq_req = '0;
		i_iq_req.tag = 4'h1;
		i_iq_valid = 1'b1;
		#1;
		rdy = o_iq_ready;
		i_iq_valid = 1'b0; // withdrawn before the edge
		check_true(rdy, "o_iq_ready low for a load after reset");
		idle(1);
		end_test("reset", e0);
	endtask

	task automatic test_ready_base();
		int e0;
		int cyc;
		e0 = errors;
		send_op(new_tag(), 1'b0, make_operand('0, $urandom), make_operand('0, '0), 12'h010);
		cyc = 1;
		while (!o_mu_valid && cyc < TIMEOUT) begin
			@(posedge clk);
			#DRIVE;
			cyc++;
		end
		check_true(cyc == 3, "load did not reach the memory unit in its third cycle");
		wait_drain("ready-base load");
		send_op(new_tag(), 1'b0, make_operand('0, $urandom), make_operand('0, '0), 12'hf9c);
		wait_drain("negative-offset load");
		end_test("ready_base_load", e0);
	endtask

	task automatic test_wakeup();
		int e0;
		e0 = errors;
		send_op(new_tag(), 1'b0, make_operand(4'hb, '0), make_operand('0, '0), 12'h004);
		send_op(new_tag(), 1'b1, make_operand('0, $urandom), make_operand(4'hc, '0), 12'h7ff);
		send_op(new_tag(), 1'b1, make_operand(4'hd, '0), make_operand('0, $urandom), 12'h800);
		idle(6);
		broadcast(4'hc, $urandom);
		idle(3);
		broadcast(4'hb, $urandom);
		idle(2);
		broadcast(4'hd, $urandom);
		wait_drain("waiting operations");
		end_test("wakeup", e0);
	endtask

	task automatic test_ordering();
		int e0;
		logic [TAG_W-1:0] ts, tl;
		logic [DATA_W-1:0] a;
		e0 = errors;
		a = $urandom;
		ts = new_tag();
		tl = new_tag();
		send_op(ts, 1'b1, make_operand('0, a), make_operand(4'h9, '0), '0);
		send_op(tl, 1'b0, make_operand('0, a), make_operand('0, '0), '0);
		idle(4);
		check_true(pend[tl], "load left ahead of an older store to its address");
		broadcast(4'h9, $urandom);
		wait_drain("same-address pair");
		// different address, the load does not wait for the store
		ts = new_tag();
		tl = new_tag();
		send_op(ts, 1'b1, make_operand('0, 32'h1000), make_operand(4'h7, '0), '0);
		send_op(tl, 1'b0, make_operand('0, 32'h2000), make_operand('0, '0), '0);
		wait_issue(tl);
		check_true(pend[ts], "store issued before its data arrived");
		broadcast(4'h7, $urandom);
		wait_drain("different-address pair");
		end_test("ordering", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		int n;
		logic rdy_ld, rdy_st;
		e0 = errors;
		mu_mode = 1;
		for (int i = 0; i < 4; i++)
			send_op(new_tag(), 1'b0, make_operand('0, $urandom), make_operand('0, '0),
				IMM_W'($urandom));
		n = 0;
		while (!o_mu_valid && n < TIMEOUT) begin
			@(posedge clk);
			#DRIVE;
			n++;
		end
		if (!o_mu_valid) begin
			errors++;
			$display("timed out waiting for o_mu_valid with all load slots in use");
		end
		i_iq_req.is_store = 1'b0;
		#1;
		rdy_ld = o_iq_ready;
		i_iq_req.is_store = 1'b1;
		#1;
		rdy_st = o_iq_ready;
		idle(1);
		check_true(!rdy_ld, "o_iq_ready high for a load with all load slots full");
		check_true(rdy_st, "o_iq_ready low for a store with free store slots");
		for (int i = 0; i < 2; i++)
			send_op(new_tag(), 1'b1, make_operand('0, $urandom), make_operand('0, $urandom),
				IMM_W'($urandom));
		idle(5);
		mu_mode = 2;
		wait_drain("back-pressured operations");
		mu_mode = 0;
		end_test("backpressure", e0);
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst_n = 1'b0;
		i_iq_valid = 1'b0;
		i_iq_req = '0;
		i_cdb = '0;
		i_mu_ready = 1'b1;
		mu_mode = 0;
		tag_ctr = '0;
		repeat (5) @(posedge clk);
		#DRIVE;
		rst_n = 1'b1;
		test_reset();
		test_ready_base();
		test_wakeup();
		test_ordering();
		test_backpressure();
		check_true(accept_cnt == issue_cnt, "accepted and issued counts differ");
		$display("tests %0d, failed %0d, errors %0d, accepted %0d, issued %0d",
			tests_run, tests_failed, errors, accept_cnt, issue_cnt);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
lsq_pkg.sv
lsq_addr_queue.sv
lsq_entry_table.sv
lsq_issue_select.sv
lsq_top.sv
tb_lsq_top.sv
